// ==== include/icache_settings.svh ====
// cache geometry and address field widths, included by the package and by every RTL file
`ifndef ICACHE_SETTINGS_SVH
`define ICACHE_SETTINGS_SVH

// ------------------------------------------------------------
// base geometry
// ------------------------------------------------------------
`define ICACHE_ADDR_W     32
`define ICACHE_WORD_W     64
`define ICACHE_LINE_WORDS 4
`define ICACHE_SETS       64

// fixed at two, the victim choice only knows two ways
`define ICACHE_WAYS       2

// ------------------------------------------------------------
// derived widths
// ------------------------------------------------------------
`define ICACHE_BEAT_W     ($clog2(`ICACHE_LINE_WORDS))
`define ICACHE_OFFSET_W   ($clog2(`ICACHE_LINE_WORDS * `ICACHE_WORD_W / 8))
`define ICACHE_INDEX_W    ($clog2(`ICACHE_SETS))
`define ICACHE_TAG_W      (`ICACHE_ADDR_W - `ICACHE_INDEX_W - `ICACHE_OFFSET_W)

`endif

// ==== verilog/icache_pkg.sv ====
// shared types of the instruction cache, imported by wildcard in each RTL module header
`include "icache_settings.svh"

package icache_pkg;

  // ------------------------------------------------------------
  // address and array payloads
  // ------------------------------------------------------------
  typedef struct packed {
    logic [`ICACHE_TAG_W-1:0]    tag;
    logic [`ICACHE_INDEX_W-1:0]  index;
    logic [`ICACHE_OFFSET_W-1:0] offset;
  } icache_addr_t;

  typedef struct packed {
    logic                     valid;
    logic [`ICACHE_TAG_W-1:0] tag;
  } icache_tag_entry_t;

  typedef logic [`ICACHE_WORD_W-1:0] icache_word_t;

  typedef icache_word_t [`ICACHE_LINE_WORDS-1:0] icache_line_t;  // word 0 at the low end

  typedef logic [`ICACHE_BEAT_W-1:0] icache_beat_t;              // word position / beat count

  // ------------------------------------------------------------
  // main FSM
  // ------------------------------------------------------------
  typedef enum logic [1:0] {
    IDLE,
    LOOKUP,
    REPLACE,
    REFILL
  } icache_state_e;

  // word position inside the line, the upper offset bits
  function automatic icache_beat_t icache_word_pos(input icache_addr_t addr);
    return addr.offset[`ICACHE_OFFSET_W-1 -: `ICACHE_BEAT_W];
  endfunction

endpackage

// ==== verilog/icache_sram.sv ====
// behavioural single-port array with registered read, one entry per set, for tags and lines
`timescale 1ns/1ps
`include "icache_settings.svh"

module icache_sram #(
  parameter type entry_t = logic,
  parameter int  SETS    = `ICACHE_SETS
) (
  input  logic                    i_clk,
  input  logic                    i_rst,
  input  logic                    i_en,
  input  logic                    i_we,
  input  logic [$clog2(SETS)-1:0] i_index,
  input  entry_t                  i_wdata,
  output entry_t                  o_rdata
);

  entry_t mem [SETS];

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      for (int s = 0; s < SETS; s++) begin
        mem[s] <= '0;                     // clears valid in the tag arrays
      end
      o_rdata <= '0;
    end else if (i_en) begin
      if (i_we) begin
        mem[i_index] <= i_wdata;
        o_rdata      <= i_wdata;          // held read follows the write
      end else begin
        o_rdata <= mem[i_index];          // data out one cycle later
      end
    end
  end

  // enables are composed in the top level from read and refill strobes
  a_we_needs_en: assert property (
    @(posedge i_clk) disable iff (i_rst)
    i_we |-> i_en
  ) else $error("array write without enable");

endmodule

// ==== verilog/icache_tag_match.sv ====
// tag compare of both ways against the buffered request, with hit word select
`timescale 1ns/1ps
`include "icache_settings.svh"

module icache_tag_match
  import icache_pkg::*;
(
  input  icache_addr_t                         i_req,
  input  icache_tag_entry_t [`ICACHE_WAYS-1:0] i_tags,
  input  icache_line_t      [`ICACHE_WAYS-1:0] i_lines,
  output logic                                 o_hit,
  output logic              [`ICACHE_WAYS-1:0] o_valid_ways,
  output icache_word_t                         o_word
);

  logic [`ICACHE_WAYS-1:0] way_hit;
  icache_beat_t            word_pos;

  // ------------------------------------------------------------
  // compare
  // ------------------------------------------------------------
  always_comb begin
    for (int w = 0; w < `ICACHE_WAYS; w++) begin
      o_valid_ways[w] = i_tags[w].valid;
      way_hit[w]      = i_tags[w].valid && (i_tags[w].tag == i_req.tag);
    end
  end

  assign o_hit    = |way_hit;
  assign word_pos = icache_word_pos(i_req);   // offset[4:3]

  // ------------------------------------------------------------
  // word select
  // ------------------------------------------------------------
  always_comb begin
    o_word = '0;
    for (int w = 0; w < `ICACHE_WAYS; w++) begin
      if (way_hit[w]) begin
        o_word = o_word | i_lines[w][word_pos];  // and-or, at most one way
      end
    end
  end

  // a line lives in only one way, the refill picks a way that missed
  always_comb begin
    a_single_way_hit: assert final ($onehot0(way_hit))
      else $error("tag hit in more than one way");
  end

endmodule

// ==== verilog/icache_miss_buffer.sv ====
// miss bookkeeping: victim way choice, returned beat count and the per-beat line write
`timescale 1ns/1ps
`include "icache_settings.svh"

module icache_miss_buffer
  import icache_pkg::*;
(
  input  logic                    i_clk,
  input  logic                    i_rst,
  input  logic                    i_start,
  input  logic [`ICACHE_WAYS-1:0] i_valid_ways,
  input  logic                    i_ret_valid,
  input  logic                    i_ret_last,
  input  icache_word_t            i_ret_data,
  input  icache_line_t            i_old_line,
  output logic                    o_victim,
  output icache_beat_t            o_beat,
  output icache_line_t            o_line
);

  localparam icache_beat_t LAST_BEAT = icache_beat_t'(`ICACHE_LINE_WORDS - 1);

  logic toggle_q;                         // round robin once both ways are valid

  // ------------------------------------------------------------
  // victim choice
  // ------------------------------------------------------------
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_victim <= 1'b0;
      toggle_q <= 1'b0;
    end else if (i_start) begin
      if (!i_valid_ways[0]) begin
        o_victim <= 1'b0;                 // first invalid way wins
      end else if (!i_valid_ways[1]) begin
        o_victim <= 1'b1;
      end else begin
        o_victim <= toggle_q;
        toggle_q <= ~toggle_q;            // flips only on a real eviction
      end
    end
  end

  // ------------------------------------------------------------
  // beat count
  // ------------------------------------------------------------
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_beat <= '0;
    end else if (i_start) begin
      o_beat <= '0;
    end else if (i_ret_valid) begin
      o_beat <= o_beat + 1'b1;            // wraps back to 0 after the last beat
    end
  end

  // current beat into its slot, rest from the held victim read
  always_comb begin
    o_line         = i_old_line;
    o_line[o_beat] = i_ret_data;
  end

  a_last_on_fourth: assert property (
    @(posedge i_clk) disable iff (i_rst)
    i_ret_last |-> (i_ret_valid && o_beat == LAST_BEAT)
  ) else $error("ret_last not on the final beat");

endmodule

// ==== verilog/icache_ctrl.sv ====
// request buffer, main FSM and the CPU and memory handshakes of the instruction cache
`timescale 1ns/1ps
`include "icache_settings.svh"

module icache_ctrl
  import icache_pkg::*;
(
  input  logic                       i_clk,
  input  logic                       i_rst,
  input  logic                       i_valid,
  input  icache_addr_t               i_addr,
  input  logic                       i_hit,
  input  icache_word_t               i_word,
  input  icache_beat_t               i_beat,
  input  logic                       i_victim,
  input  logic                       i_rd_rdy,
  input  logic                       i_ret_valid,
  input  logic                       i_ret_last,
  input  icache_word_t               i_ret_data,
  output icache_addr_t               o_req,
  output logic [`ICACHE_INDEX_W-1:0] o_index,
  output logic                       o_rd_en,
  output logic [`ICACHE_WAYS-1:0]    o_refill_we,
  output logic                       o_start,
  output logic                       o_addr_ok,
  output logic                       o_data_ok,
  output icache_word_t               o_rdata,
  output logic                       o_rd_req,
  output logic [`ICACHE_ADDR_W-1:0]  o_rd_addr
);

  icache_state_e state_q;
  icache_state_e state_d;
  logic          lookup_hit;
  logic          lookup_miss;
  logic          accept;
  logic          critical;

  assign lookup_hit  = (state_q == LOOKUP) && i_hit;
  assign lookup_miss = (state_q == LOOKUP) && !i_hit;

  // ------------------------------------------------------------
  // request buffer
  // ------------------------------------------------------------
  assign o_addr_ok = (state_q == IDLE) || (lookup_hit && i_valid);  // hit can chain
  assign accept    = i_valid && o_addr_ok;

  always_ff @(posedge i_clk) begin
    if (accept) begin
      o_req <= i_addr;
    end
  end

  // array port: live address while looking up, held one during the miss
  assign o_index = (state_q == IDLE || state_q == LOOKUP) ? i_addr.index : o_req.index;
  assign o_rd_en = accept;

  // ------------------------------------------------------------
  // main FSM
  // ------------------------------------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:    if (accept) state_d = LOOKUP;
      LOOKUP: begin
        if (i_hit) begin
          state_d = i_valid ? LOOKUP : IDLE;
        end else begin
          state_d = i_rd_rdy ? REFILL : REPLACE;   // request already on the bus
        end
      end
      REPLACE: if (i_rd_rdy) state_d = REFILL;
      REFILL:  if (i_ret_valid && i_ret_last) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // ------------------------------------------------------------
  // memory side
  // ------------------------------------------------------------
  assign o_rd_req  = lookup_miss || (state_q == REPLACE);
  assign o_start   = o_rd_req && i_rd_rdy;
  assign o_rd_addr = {o_req.tag, o_req.index, {`ICACHE_OFFSET_W{1'b0}}};  // line aligned

  always_comb begin
    o_refill_we = '0;
    if (state_q == REFILL && i_ret_valid) begin
      o_refill_we[i_victim] = 1'b1;      // one beat per cycle into the victim
    end
  end

  // ------------------------------------------------------------
  // CPU answer
  // ------------------------------------------------------------
  assign critical  = (state_q == REFILL) && i_ret_valid && (i_beat == icache_word_pos(o_req));
  assign o_data_ok = lookup_hit || critical;
  assign o_rdata   = lookup_hit ? i_word : i_ret_data;

  a_rd_req_hold: assert property (
    @(posedge i_clk) disable iff (i_rst)
    (o_rd_req && !i_rd_rdy) |=> (o_rd_req && $stable(o_rd_addr))
  ) else $error("rd_req dropped before rd_rdy");

endmodule

// ==== verilog/icache_top.sv ====
// two-way instruction cache top, ties the controller, tag match, miss buffer and arrays together
`timescale 1ns/1ps
`include "icache_settings.svh"

module icache_top
  import icache_pkg::*;
(
  input  logic                      i_clk,
  input  logic                      i_rst,
  // CPU fetch port
  input  logic                      i_valid,
  input  icache_addr_t              i_addr,
  output logic                      o_addr_ok,
  output logic                      o_data_ok,
  output icache_word_t              o_rdata,
  // burst read port
  output logic                      o_rd_req,
  output logic [`ICACHE_ADDR_W-1:0] o_rd_addr,
  input  logic                      i_rd_rdy,
  input  logic                      i_ret_valid,
  input  logic                      i_ret_last,
  input  icache_word_t              i_ret_data
);

  icache_addr_t                         req;
  logic [`ICACHE_INDEX_W-1:0]           index;
  logic                                 rd_en;
  logic [`ICACHE_WAYS-1:0]              refill_we;
  logic                                 start;
  logic                                 hit;
  icache_word_t                         hit_word;
  logic [`ICACHE_WAYS-1:0]              valid_ways;
  logic                                 victim;
  icache_beat_t                         beat;
  icache_line_t                         fill_line;
  icache_tag_entry_t [`ICACHE_WAYS-1:0] tag_rd;
  icache_line_t      [`ICACHE_WAYS-1:0] line_rd;
  icache_tag_entry_t                    tag_wdata;

  assign tag_wdata = '{valid: 1'b1, tag: req.tag};

  icache_ctrl ctrl_inst (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_valid     (i_valid),
    .i_addr      (i_addr),
    .i_hit       (hit),
    .i_word      (hit_word),
    .i_beat      (beat),
    .i_victim    (victim),
    .i_rd_rdy    (i_rd_rdy),
    .i_ret_valid (i_ret_valid),
    .i_ret_last  (i_ret_last),
    .i_ret_data  (i_ret_data),
    .o_req       (req),
    .o_index     (index),
    .o_rd_en     (rd_en),
    .o_refill_we (refill_we),
    .o_start     (start),
    .o_addr_ok   (o_addr_ok),
    .o_data_ok   (o_data_ok),
    .o_rdata     (o_rdata),
    .o_rd_req    (o_rd_req),
    .o_rd_addr   (o_rd_addr)
  );

  icache_tag_match tag_match_inst (
    .i_req        (req),
    .i_tags       (tag_rd),
    .i_lines      (line_rd),
    .o_hit        (hit),
    .o_valid_ways (valid_ways),
    .o_word       (hit_word)
  );

  icache_miss_buffer miss_buffer_inst (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_start      (start),
    .i_valid_ways (valid_ways),
    .i_ret_valid  (i_ret_valid),
    .i_ret_last   (i_ret_last),
    .i_ret_data   (i_ret_data),
    .i_old_line   (line_rd[victim]),   // victim read held since lookup
    .o_victim     (victim),
    .o_beat       (beat),
    .o_line       (fill_line)
  );

  // ------------------------------------------------------------
  // per-way tag and data arrays
  // ------------------------------------------------------------
  for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : g_way
    logic way_en;
    logic tag_we;

    assign way_en = rd_en | refill_we[w];
    assign tag_we = refill_we[w] & i_ret_last;   // tag turns valid with the last beat

    icache_sram #(
      .entry_t (icache_tag_entry_t),
      .SETS    (`ICACHE_SETS)
    ) tag_ram_inst (
      .i_clk   (i_clk),
      .i_rst   (i_rst),
      .i_en    (way_en),
      .i_we    (tag_we),
      .i_index (index),
      .i_wdata (tag_wdata),
      .o_rdata (tag_rd[w])
    );

    icache_sram #(
      .entry_t (icache_line_t),
      .SETS    (`ICACHE_SETS)
    ) data_ram_inst (
      .i_clk   (i_clk),
      .i_rst   (i_rst),
      .i_en    (way_en),
      .i_we    (refill_we[w]),
      .i_index (index),
      .i_wdata (fill_line),
      .o_rdata (line_rd[w])
    );
  end

endmodule

// ==== sim/icache_mem_model.sv ====
// burst read responder for the cache testbench, answers each accepted rd_req with four beats
`timescale 1ns/1ps

module icache_mem_model
  import icache_pkg::*;
(
  input  logic         i_clk,
  input  logic         i_rst,
  input  logic         i_rd_req,
  input  logic [31:0]  i_rd_addr,
  output logic         o_rd_rdy,
  output logic         o_ret_valid,
  output logic         o_ret_last,
  output icache_word_t o_ret_data
);

  localparam logic [31:0] SEED = 32'h4a9e_d79a;

  logic [31:0] lfsr_q;
  logic [31:0] line_addr;
  int          beat;

  // fibonacci lfsr, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      val    = {val[30:0], fb};
    end
    return val;
  endfunction

  // memory contents: line address mixed with a constant, word position in the low bits
  function automatic icache_word_t beat_word(input logic [31:0] line, input int pos);
    return {line ^ 32'h9e37_79b9, line | 32'(pos)};
  endfunction

  initial begin
    lfsr_q      = SEED;
    o_rd_rdy    = 1'b0;
    o_ret_valid = 1'b0;
    o_ret_last  = 1'b0;
    o_ret_data  = '0;
    forever begin
      @(negedge i_clk);
      o_rd_rdy    = 1'b0;
      o_ret_valid = 1'b0;
      o_ret_last  = 1'b0;
      if (!i_rst && i_rd_req) begin
        if (take_bits(2) != 0) begin   // ready three times in four
          o_rd_rdy  = 1'b1;             // transfer at the next rising edge
          line_addr = i_rd_addr;
          @(negedge i_clk);
          o_rd_rdy = 1'b0;
          beat     = 0;
          while (beat < 4) begin
            if (take_bits(2) == 0) begin
              o_ret_valid = 1'b0;       // gap between beats
              o_ret_last  = 1'b0;
            end else begin
              o_ret_valid = 1'b1;
              o_ret_last  = (beat == 3);
              o_ret_data  = beat_word(line_addr, beat);
              beat++;
            end
            if (beat < 4) begin
              @(negedge i_clk);
            end
          end
        end
      end
    end
  end

endmodule

// ==== sim/icache_tb.sv ====
// instruction cache testbench that checks directed and random fetches against a reference model
`timescale 1ns/1ps
`include "icache_settings.svh"

module icache_tb
  import icache_pkg::*;
();

  localparam logic [31:0] SEED           = 32'h4a9e_d79a;
  localparam int          N_RANDOM       = 200;
  localparam int          N_REQUESTS     = 17 + N_RANDOM;  // directed plus random
  localparam int          WORST_REFILL   = 40;             // rdy wait plus gapped beats
  localparam int          TIMEOUT_CYCLES = N_REQUESTS * WORST_REFILL * 2;

  typedef struct packed {
    icache_word_t word;
    logic         hit;
    logic [31:0]  cycle;
  } expect_t;

  logic         i_clk;
  logic         i_rst;
  logic         i_valid;
  icache_addr_t i_addr;
  logic         o_addr_ok;
  logic         o_data_ok;
  icache_word_t o_rdata;
  logic         o_rd_req;
  logic [31:0]  o_rd_addr;
  logic         i_rd_rdy;
  logic         i_ret_valid;
  logic         i_ret_last;
  icache_word_t i_ret_data;

  expect_t                  exp_q[$];
  logic [31:0]              rd_q[$];
  logic                     ref_valid [`ICACHE_WAYS][`ICACHE_SETS];
  logic [`ICACHE_TAG_W-1:0] ref_tag [`ICACHE_WAYS][`ICACHE_SETS];
  logic                     ref_toggle;
  logic [31:0]              lfsr_q;
  logic [31:0]              cycle_q;
  int errors, checks, rd_count, model_misses, hit_answers, tests_run, tests_bad;
  int err_mark, rd_mark, miss_mark, hit_mark;

  initial i_clk = 1'b0;
  always #20 i_clk = ~i_clk;

  icache_top icache_top_inst (
    .i_clk (i_clk), .i_rst (i_rst), .i_valid (i_valid), .i_addr (i_addr),
    .o_addr_ok (o_addr_ok), .o_data_ok (o_data_ok), .o_rdata (o_rdata),
    .o_rd_req (o_rd_req), .o_rd_addr (o_rd_addr), .i_rd_rdy (i_rd_rdy),
    .i_ret_valid (i_ret_valid), .i_ret_last (i_ret_last), .i_ret_data (i_ret_data)
  );

  icache_mem_model mem_model_inst (
    .i_clk (i_clk), .i_rst (i_rst), .i_rd_req (o_rd_req), .i_rd_addr (o_rd_addr),
    .o_rd_rdy (i_rd_rdy), .o_ret_valid (i_ret_valid), .o_ret_last (i_ret_last),
    .o_ret_data (i_ret_data)
  );

  // ------------------------------------------------------------
  // reference functions
  // ------------------------------------------------------------
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      val    = {val[30:0], fb};
    end
    return val;
  endfunction

  function automatic icache_word_t expected_word(input icache_addr_t a);
    logic [31:0] line;
    line = {a.tag, a.index, 5'b00000};
    return {line ^ 32'h9e37_79b9, line | {30'b0, a.offset[4:3]}};
  endfunction

  // returns hit and fills the first invalid or toggled way on a miss
  function automatic logic model_access(input icache_addr_t a);
    int way;
    for (int w = 0; w < `ICACHE_WAYS; w++) begin
      if (ref_valid[w][a.index] && ref_tag[w][a.index] == a.tag) begin
        return 1'b1;
      end
    end
    if (!ref_valid[0][a.index]) begin
      way = 0;
    end else if (!ref_valid[1][a.index]) begin
      way = 1;
    end else begin
      way        = ref_toggle;
      ref_toggle = !ref_toggle;
    end
    ref_valid[way][a.index] = 1'b1;
    ref_tag[way][a.index]   = a.tag;
    return 1'b0;
  endfunction

  function automatic icache_addr_t make_addr(input logic [20:0] tag, input logic [5:0] index,
                                             input logic [1:0] word);
    icache_addr_t a;
    a.tag    = tag;
    a.index  = index;
    a.offset = {word, 3'b000};
    return a;
  endfunction

  task automatic compare_value(input string sig, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, sig, got, exp);
      errors++;
    end
  endtask

  task automatic require(input logic cond, input string what);
    checks++;
    assert (cond) else begin
      $display("error at %0t: %s", $time, what);
      errors++;
    end
  endtask

  // ------------------------------------------------------------
  // compare process on the rising edge
  // ------------------------------------------------------------
  always @(posedge i_clk) begin : monitor
    expect_t head;
    expect_t entry;
    if (!i_rst) begin
      if (o_data_ok) begin
        if (exp_q.size() == 0) begin
          require(1'b0, "data_ok with no request outstanding");
        end else begin
          head = exp_q.pop_front();
          compare_value("o_rdata", o_rdata, head.word);
          if (cycle_q - head.cycle == 1) begin
            hit_answers++;                   // answered in the hit slot
          end
          if (head.hit) begin
            compare_value("data_ok latency", cycle_q - head.cycle, 1);
          end else begin
            require(i_ret_valid, "miss answered outside a returned beat");
          end
        end
      end
      if (i_ret_valid && i_ret_last) begin
        require(exp_q.size() == 0, "refill ended before the requested word came back");
      end
      if (o_rd_req && i_rd_rdy) begin
        rd_count++;
        if (rd_q.size() == 0) begin
          require(1'b0, "rd_req issued for a request that should hit");
        end else begin
          compare_value("o_rd_addr", o_rd_addr, rd_q.pop_front());
        end
      end
      if (i_valid && o_addr_ok) begin
        entry.word  = expected_word(i_addr);
        entry.hit   = model_access(i_addr);
        entry.cycle = cycle_q;
        exp_q.push_back(entry);
        if (!entry.hit) begin
          model_misses++;
          rd_q.push_back({i_addr.tag, i_addr.index, 5'b00000});
        end
      end
    end
  end

  always @(posedge i_clk) begin
    cycle_q <= cycle_q + 1;
    if (cycle_q == TIMEOUT_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("sim failed");
      $finish;
    end
  end

  // ------------------------------------------------------------
  // stimulus tasks
  // ------------------------------------------------------------
  task automatic issue(input icache_addr_t addr, output logic [31:0] accepted_at);
    @(negedge i_clk);
    i_valid = 1'b1;
    i_addr  = addr;
    @(posedge i_clk);
    while (!o_addr_ok) begin
      @(posedge i_clk);
    end
    accepted_at = cycle_q;
  endtask

  task automatic go_idle();
    @(negedge i_clk);
    i_valid = 1'b0;
  endtask

  task automatic drain();
    go_idle();
    while (exp_q.size() != 0 || rd_q.size() != 0 || !o_addr_ok) begin
      @(negedge i_clk);
    end
  endtask

  task automatic mark_start();
    err_mark  = errors;
    rd_mark   = rd_count;
    miss_mark = model_misses;
    hit_mark  = hit_answers;
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (errors == err_mark) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_bad++;
      $display("test %0d %s: %0d errors", tests_run, name, errors - err_mark);
    end
  endtask

  initial begin
    logic [31:0] t_first;
    logic [31:0] t_last;
    logic [20:0] set_tags [3];
    int          order [7];
    i_rst   = 1'b1;
    i_valid = 1'b0;
    i_addr  = '0;
    lfsr_q  = SEED;
    cycle_q = '0;
    {errors, checks, rd_count, model_misses, hit_answers, tests_run, tests_bad} = '0;
    ref_toggle = 1'b0;
    for (int w = 0; w < `ICACHE_WAYS; w++) begin
      for (int s = 0; s < `ICACHE_SETS; s++) begin
        ref_valid[w][s] = 1'b0;
      end
    end
    repeat (2) @(posedge i_clk);
    @(negedge i_clk);
    i_rst = 1'b0;

    mark_start();
    issue(make_addr(21'h01234, 6'd1, 2'd2), t_first);
    drain();
    compare_value("rd_req count", rd_count - rd_mark, 1);
    finish_test("cold miss");

    mark_start();
    issue(make_addr(21'h01234, 6'd1, 2'd0), t_first);
    drain();
    compare_value("rd_req count", rd_count - rd_mark, 0);
    compare_value("hit count", hit_answers - hit_mark, 1);
    finish_test("hit on same line");

    mark_start();
    for (int w = 0; w < 4; w++) begin
      issue(make_addr(21'h01234, 6'd1, 2'(w)), t_last);
      if (w == 0) begin
        t_first = t_last;
      end
    end
    drain();
    compare_value("accept cycle spread", t_last - t_first, 3);   // one per cycle
    compare_value("rd_req count", rd_count - rd_mark, 0);
    compare_value("hit count", hit_answers - hit_mark, 4);
    finish_test("back-to-back hits");

    mark_start();
    for (int w = 0; w < 4; w++) begin
      issue(make_addr(21'h02000 + 21'(w), 6'(2 + w), 2'(w)), t_last);
    end
    drain();
    compare_value("rd_req count", rd_count - rd_mark, 4);
    finish_test("critical word");

    // set 9 sees A B C A B A C and with the toggle at 0 only the third A hits
    mark_start();
    set_tags = '{21'h00a01, 21'h00b02, 21'h00c03};
    order    = '{0, 1, 2, 0, 1, 0, 2};
    for (int i = 0; i < 7; i++) begin
      issue(make_addr(set_tags[order[i]], 6'd9, 2'(i)), t_last);
    end
    drain();
    compare_value("rd_req count", rd_count - rd_mark, model_misses - miss_mark);
    compare_value("rd_req count", rd_count - rd_mark, 6);
    finish_test("three lines one set");

    mark_start();
    for (int i = 0; i < N_RANDOM; i++) begin
      issue(make_addr(21'h01f00 + 21'(take_bits(2)), 6'(take_bits(3)), 2'(take_bits(2))),
            t_last);
      if (take_bits(1) == 1) begin
        go_idle();                     // idle cycle between requests
      end
    end
    drain();
    compare_value("rd_req count", rd_count - rd_mark, model_misses - miss_mark);
    finish_test("random fetches");

    $display("tests run: %0d, with errors: %0d, checks: %0d, errors: %0d",
             tests_run, tests_bad, checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// ==== sim.f ====
+incdir+include
verilog/icache_pkg.sv
verilog/icache_sram.sv
verilog/icache_tag_match.sv
verilog/icache_miss_buffer.sv
verilog/icache_ctrl.sv
verilog/icache_top.sv
sim/icache_mem_model.sv
sim/icache_tb.sv
